/* hw/chdr_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the CHDR ingress port. Beat width is fixed at chdr_w;
// modules check their WIDTH parameter against it at elaboration.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package chdr_pkg;

  localparam int chdr_w = 64;

  // One stream beat with its end-of-packet marker
  typedef struct packed {
    logic              last;
    logic [chdr_w-1:0] data;
  } chdr_beat_t;

  // Header field positions in the first beat
  localparam int len_lsb  = 0;
  localparam int len_msb  = 15;
  localparam int seq_lsb  = 16;
  localparam int seq_msb  = 31;
  localparam int type_lsb = 61;
  localparam int type_msb = 63;

  localparam int beat_bytes = 8;
  localparam int cnt_w      = 16;

  // Codes 3 and 5 are reserved
  typedef enum logic [2:0] {
    PKT_MGMT     = 3'd0,
    PKT_STRS     = 3'd1,
    PKT_STRC     = 3'd2,
    PKT_CTRL     = 3'd4,
    PKT_DATA     = 3'd6,
    PKT_DATA_EOB = 3'd7
  } chdr_pkt_type_e;

  typedef enum logic {
    ST_HEADER = 1'b0,
    ST_BODY   = 1'b1
  } chk_state_e;

endpackage

/* hw/axis_flop2.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry register FIFO. Output is always registered and o_ready
// comes from state only, so it breaks both forward and backward paths.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module axis_flop2 #(
  parameter int WIDTH = chdr_pkg::chdr_w
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  chdr_pkg::chdr_beat_t i_beat,
  input  logic                 i_valid,
  output logic                 o_ready,
  output chdr_pkg::chdr_beat_t o_beat,
  output logic                 o_valid,
  input  logic                 i_ready
);

  if (WIDTH != chdr_pkg::chdr_w) begin : g_width_chk
    $error("axis_flop2: WIDTH must equal the beat data width");
  end

  chdr_pkg::chdr_beat_t main_q;
  chdr_pkg::chdr_beat_t skid_q;
  logic [1:0]           count;
  logic                 push;
  logic                 pop;

  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;
  assign o_valid = (count != 2'd0);
  assign o_ready = (count != 2'd2);
  assign o_beat  = main_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      count <= 2'd0;
    end else if (push && !pop) begin
      count <= count + 2'd1;
    end else if (pop && !push) begin
      count <= count - 2'd1;
    end
  end

  // Main holds the head; skid only fills when main is stuck
  always_ff @(posedge i_clk) begin
    if (push && ((count == 2'd0) || ((count == 2'd1) && pop))) begin
      main_q <= i_beat;
    end else if (pop && (count == 2'd2)) begin
      main_q <= skid_q;
    end
    if (push && (count == 2'd1) && !pop) begin
      skid_q <= i_beat;
    end
  end

endmodule

/* hw/axis_ram_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-clock RAM FIFO, 2**SIZE entries plus one output register.
// Read is registered, so a beat needs two cycles to reach the output.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module axis_ram_fifo #(
  parameter int WIDTH = chdr_pkg::chdr_w,
  parameter int SIZE  = 9
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  chdr_pkg::chdr_beat_t i_beat,
  input  logic                 i_valid,
  output logic                 o_ready,
  output chdr_pkg::chdr_beat_t o_beat,
  output logic                 o_valid,
  input  logic                 i_ready
);

  localparam int DEPTH = 2 ** SIZE;

  if (WIDTH != chdr_pkg::chdr_w) begin : g_width_chk
    $error("axis_ram_fifo: WIDTH must equal the beat data width");
  end

  // Stored as last plus data
  logic [WIDTH:0] mem [DEPTH];
  logic [SIZE:0]  wr_ptr;
  logic [SIZE:0]  rd_ptr;
  logic [SIZE:0]  used;
  logic           empty;
  logic           push;
  logic           rd_en;

  // Pointers carry one extra bit so full and empty differ
  assign used    = wr_ptr - rd_ptr;
  assign empty   = (used == '0);
  assign o_ready = !used[SIZE];
  assign push    = i_valid && o_ready;

  // Load the output register when it is free or draining
  assign rd_en = !empty && (!o_valid || i_ready);

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr[SIZE-1:0]] <= i_beat;
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_en) begin
      o_beat <= mem[rd_ptr[SIZE-1:0]];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr  <= rd_ptr + 1'b1;
        o_valid <= 1'b1;
      end else if (i_ready) begin
        o_valid <= 1'b0;
      end
    end
  end

endmodule

/* hw/chdr_ingress_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ingress buffer. Above CASCADE_SIZE the depth is split into
// 2**(SIZE-CASCADE_SIZE) RAM stages; each stage adds 3 cycles of latency.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module chdr_ingress_fifo #(
  parameter int WIDTH        = chdr_pkg::chdr_w,
  parameter int SIZE         = 12,
  parameter int CASCADE_SIZE = 12
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  chdr_pkg::chdr_beat_t i_beat,
  input  logic                 i_valid,
  output logic                 o_ready,
  output chdr_pkg::chdr_beat_t o_beat,
  output logic                 o_valid,
  input  logic                 i_ready
);

  chdr_pkg::chdr_beat_t pre_beat;
  logic                 pre_valid;
  logic                 pre_ready;

  // Register stage ahead of the RAM for timing
  axis_flop2 #(.WIDTH(WIDTH)) pre_stage (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_beat(i_beat), .i_valid(i_valid), .o_ready(o_ready),
    .o_beat(pre_beat), .o_valid(pre_valid), .i_ready(pre_ready)
  );

  if (SIZE <= CASCADE_SIZE) begin : g_single
    chdr_pkg::chdr_beat_t ram_beat;
    logic                 ram_valid;
    logic                 ram_ready;

    axis_ram_fifo #(.WIDTH(WIDTH), .SIZE(SIZE)) ram_fifo (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_beat(pre_beat), .i_valid(pre_valid), .o_ready(pre_ready),
      .o_beat(ram_beat), .o_valid(ram_valid), .i_ready(ram_ready)
    );

    axis_flop2 #(.WIDTH(WIDTH)) post_stage (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_beat(ram_beat), .i_valid(ram_valid), .o_ready(ram_ready),
      .o_beat(o_beat), .o_valid(o_valid), .i_ready(i_ready)
    );
  end else begin : g_cascade
    localparam int CDEPTH = 2 ** (SIZE - CASCADE_SIZE);

    // Link k feeds stage k; link CDEPTH is the output
    chdr_pkg::chdr_beat_t c_beat [CDEPTH+1];
    logic [CDEPTH:0]      c_valid;
    logic [CDEPTH:0]      c_ready;

    assign c_beat[0]  = pre_beat;
    assign c_valid[0] = pre_valid;
    assign pre_ready  = c_ready[0];

    assign o_beat          = c_beat[CDEPTH];
    assign o_valid         = c_valid[CDEPTH];
    assign c_ready[CDEPTH] = i_ready;

    for (genvar i = 0; i < CDEPTH; i++) begin : g_stage
      chdr_pkg::chdr_beat_t ram_beat;
      logic                 ram_valid;
      logic                 ram_ready;

      axis_ram_fifo #(.WIDTH(WIDTH), .SIZE(CASCADE_SIZE)) ram_fifo (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_beat(c_beat[i]), .i_valid(c_valid[i]), .o_ready(c_ready[i]),
        .o_beat(ram_beat), .o_valid(ram_valid), .i_ready(ram_ready)
      );

      axis_flop2 #(.WIDTH(WIDTH)) post_stage (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_beat(ram_beat), .i_valid(ram_valid), .o_ready(ram_ready),
        .o_beat(c_beat[i+1]), .o_valid(c_valid[i+1]), .i_ready(c_ready[i+1])
      );
    end
  end

endmodule

/* hw/chdr_hdr_check.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header checker on a pass-through link. Bad packets are only flagged,
// never dropped. Counters saturate at their maximum value.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module chdr_hdr_check #(
  parameter int WIDTH = chdr_pkg::chdr_w
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  chdr_pkg::chdr_beat_t           i_beat,
  input  logic                           i_valid,
  output logic                           o_ready,
  output chdr_pkg::chdr_beat_t           o_beat,
  output logic                           o_valid,
  input  logic                           i_ready,
  output chdr_pkg::chdr_pkt_type_e       o_pkt_type,
  output logic                           o_len_err,
  output logic [chdr_pkg::cnt_w-1:0]     o_pkt_cnt,
  output logic [chdr_pkg::cnt_w-1:0]     o_err_cnt
);

  if (WIDTH != chdr_pkg::chdr_w) begin : g_width_chk
    $error("chdr_hdr_check: WIDTH must equal the beat data width");
  end

  localparam int BW = chdr_pkg::cnt_w + 1;

  chdr_pkg::chk_state_e     state;
  chdr_pkg::chdr_pkt_type_e hdr_type;
  logic [15:0]              hdr_len;
  logic [15:0]              cur_len;
  logic [BW-1:0]            beat_cnt;
  logic [BW-1:0]            cur_cnt;
  logic [BW-1:0]            exp_cnt;
  logic                     is_hdr;
  logic                     xfer;

  // The stream passes straight through
  assign o_beat  = i_beat;
  assign o_valid = i_valid;
  assign o_ready = i_ready;

  assign xfer   = i_valid && i_ready;
  assign is_hdr = (state == chdr_pkg::ST_HEADER);

  // On the header beat use its own fields, later the latched ones
  assign cur_len = is_hdr ? i_beat.data[chdr_pkg::len_msb:chdr_pkg::len_lsb] : hdr_len;
  assign cur_cnt = is_hdr ? BW'(1) : ((beat_cnt == '1) ? beat_cnt : beat_cnt + 1'b1);
  assign o_pkt_type = is_hdr ?
      chdr_pkg::chdr_pkt_type_e'(i_beat.data[chdr_pkg::type_msb:chdr_pkg::type_lsb]) :
      hdr_type;

  // Length in bytes rounded up to whole beats
  assign exp_cnt = (BW'(cur_len) + BW'(chdr_pkg::beat_bytes - 1))
                   >> $clog2(chdr_pkg::beat_bytes);

  assign o_len_err = xfer && i_beat.last && (cur_cnt != exp_cnt);

  always_ff @(posedge i_clk) begin
    if (xfer && is_hdr) begin
      hdr_len  <= cur_len;
      hdr_type <= o_pkt_type;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= chdr_pkg::ST_HEADER;
      beat_cnt  <= '0;
      o_pkt_cnt <= '0;
      o_err_cnt <= '0;
    end else if (xfer) begin
      beat_cnt <= cur_cnt;
      if (i_beat.last) begin
        state <= chdr_pkg::ST_HEADER;
        if (o_pkt_cnt != '1) begin
          o_pkt_cnt <= o_pkt_cnt + 1'b1;
        end
        if (o_len_err && (o_err_cnt != '1)) begin
          o_err_cnt <= o_err_cnt + 1'b1;
        end
      end else begin
        state <= chdr_pkg::ST_BODY;
      end
    end
  end

endmodule

/* hw/chdr_ingress_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive side of a CHDR router port. Latency varies with back-pressure;
// o_pkt_type and o_len_err refer to the checker link, not o_beat.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module chdr_ingress_top #(
  parameter int WIDTH        = chdr_pkg::chdr_w,
  parameter int SIZE         = 10,
  parameter int CASCADE_SIZE = 12
) (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  chdr_pkg::chdr_beat_t       i_beat,
  input  logic                       i_valid,
  output logic                       o_ready,
  output chdr_pkg::chdr_beat_t       o_beat,
  output logic                       o_valid,
  input  logic                       i_ready,
  output chdr_pkg::chdr_pkt_type_e   o_pkt_type,
  output logic                       o_len_err,
  output logic [chdr_pkg::cnt_w-1:0] o_pkt_cnt,
  output logic [chdr_pkg::cnt_w-1:0] o_err_cnt
);

  chdr_pkg::chdr_beat_t fifo_beat;
  logic                 fifo_valid;
  logic                 fifo_ready;
  chdr_pkg::chdr_beat_t chk_beat;
  logic                 chk_valid;
  logic                 chk_ready;

  chdr_ingress_fifo #(
    .WIDTH(WIDTH), .SIZE(SIZE), .CASCADE_SIZE(CASCADE_SIZE)
  ) ingress (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_beat(i_beat), .i_valid(i_valid), .o_ready(o_ready),
    .o_beat(fifo_beat), .o_valid(fifo_valid), .i_ready(fifo_ready)
  );

  chdr_hdr_check #(.WIDTH(WIDTH)) hdr_check (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_beat(fifo_beat), .i_valid(fifo_valid), .o_ready(fifo_ready),
    .o_beat(chk_beat), .o_valid(chk_valid), .i_ready(chk_ready),
    .o_pkt_type(o_pkt_type), .o_len_err(o_len_err),
    .o_pkt_cnt(o_pkt_cnt), .o_err_cnt(o_err_cnt)
  );

  // Registered output so the port sees no combinational path
  axis_flop2 #(.WIDTH(WIDTH)) out_stage (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_beat(chk_beat), .i_valid(chk_valid), .o_ready(chk_ready),
    .o_beat(o_beat), .o_valid(o_valid), .i_ready(i_ready)
  );

endmodule

/* sim/chdr_ingress_assertions.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker bound into chdr_ingress_top. The scoreboard holds at most
// 2048 beats in flight; the length and type checks watch the checker link.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module chdr_ingress_assertions (
  input logic                 i_clk,
  input logic                 i_rst,
  input chdr_pkg::chdr_beat_t i_in_beat,
  input logic                 i_in_valid,
  input logic                 i_in_ready,
  input chdr_pkg::chdr_beat_t i_out_beat,
  input logic                 i_out_valid,
  input logic                 i_out_ready,
  input chdr_pkg::chdr_beat_t i_chk_beat,
  input logic                 i_chk_valid,
  input logic                 i_chk_ready,
  input logic [2:0]           i_pkt_type,
  input logic                 i_len_err
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned          fail_cnt = 0;
  chdr_pkg::chdr_beat_t sb_mem [2048];
  logic [10:0]          wr_idx;
  logic [10:0]          rd_idx;
  logic                 at_hdr;
  logic [15:0]          hdr_len_q;
  int                   beats_q;
  int                   cur_beats;
  logic [15:0]          cur_len;
  logic                 want_err;
  logic                 out_xfer;
  logic                 chk_xfer;

  assign out_xfer = i_out_valid && i_out_ready;
  assign chk_xfer = i_chk_valid && i_chk_ready;

  // Beats of the current packet on the checker link including this one
  assign cur_beats = at_hdr ? 1 : beats_q + 1;
  assign cur_len   = at_hdr ? i_chk_beat.data[15:0] : hdr_len_q;
  assign want_err  = (cur_beats != (int'(cur_len) + 7) / 8);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_idx  <= '0;
      rd_idx  <= '0;
      at_hdr  <= 1'b1;
      beats_q <= 0;
    end else begin
      if (i_in_valid && i_in_ready) begin
        sb_mem[wr_idx] <= i_in_beat;
        wr_idx         <= wr_idx + 11'd1;
      end
      if (out_xfer) begin
        rd_idx <= rd_idx + 11'd1;
      end
      if (chk_xfer) begin
        at_hdr  <= i_chk_beat.last;
        beats_q <= cur_beats;
        if (at_hdr) begin
          hdr_len_q <= i_chk_beat.data[15:0];
        end
      end
    end
  end

  a_order: assert property (@(posedge i_clk) disable iff (i_rst)
      out_xfer |-> (wr_idx != rd_idx) && (i_out_beat == sb_mem[rd_idx]))
    else begin
      fail_cnt++;
      $error("[ERROR] o_beat: got 0x%h, expected 0x%h",
             $sampled(i_out_beat), sb_mem[$sampled(rd_idx)]);
    end

  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_beat)))
    else begin
      fail_cnt++;
      $error("o_valid or o_beat changed while the output was stalled");
    end

  a_len_err: assert property (@(posedge i_clk) disable iff (i_rst)
      i_len_err == (chk_xfer && i_chk_beat.last && want_err))
    else begin
      fail_cnt++;
      $error("[ERROR] o_len_err: got 0x%h, expected 0x%h", $sampled(i_len_err),
             $sampled(chk_xfer && i_chk_beat.last && want_err));
    end

  a_type: assert property (@(posedge i_clk) disable iff (i_rst)
      (chk_xfer && at_hdr) |-> (i_pkt_type == i_chk_beat.data[63:61]))
    else begin
      fail_cnt++;
      $error("[ERROR] o_pkt_type: got 0x%h, expected 0x%h",
             $sampled(i_pkt_type), $sampled(i_chk_beat.data[63:61]));
    end

endmodule

bind chdr_ingress_top chdr_ingress_assertions props (
  .i_clk(i_clk), .i_rst(i_rst),
  .i_in_beat(i_beat), .i_in_valid(i_valid), .i_in_ready(o_ready),
  .i_out_beat(o_beat), .i_out_valid(o_valid), .i_out_ready(i_ready),
  .i_chk_beat(chk_beat), .i_chk_valid(chk_valid), .i_chk_ready(chk_ready),
  .i_pkt_type(o_pkt_type), .i_len_err(o_len_err)
);

/* sim/chdr_ingress_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for chdr_ingress_top with a two-stage cascade. Beat and
// header checks live in the bound assertion module.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module chdr_ingress_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAND      = 40;
  localparam int N_BURST     = 8;
  localparam int N_PKTS      = 2 * N_RAND + N_BURST;
  localparam int MAX_BEATS   = 12;
  localparam int HOLD_CYCLES = 40;
  localparam int WATCHDOG_NS = N_PKTS * MAX_BEATS * 10 * 8;

  logic                       i_clk;
  logic                       i_rst;
  chdr_pkg::chdr_beat_t       i_beat;
  logic                       i_valid;
  logic                       o_ready;
  chdr_pkg::chdr_beat_t       o_beat;
  logic                       o_valid;
  logic                       i_ready;
  chdr_pkg::chdr_pkt_type_e   o_pkt_type;
  logic                       o_len_err;
  logic [chdr_pkg::cnt_w-1:0] o_pkt_cnt;
  logic [chdr_pkg::cnt_w-1:0] o_err_cnt;

  int          errors    = 0;
  int          pkts_sent = 0;
  int          pkts_bad  = 0;
  logic [15:0] beat_num  = '0;
  logic [15:0] seq_num   = '0;
  logic        stall;

  chdr_ingress_top #(
    .WIDTH(chdr_pkg::chdr_w), .SIZE(5), .CASCADE_SIZE(4)
  ) dut (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_beat(i_beat), .i_valid(i_valid), .o_ready(o_ready),
    .o_beat(o_beat), .o_valid(o_valid), .i_ready(i_ready),
    .o_pkt_type(o_pkt_type), .o_len_err(o_len_err),
    .o_pkt_cnt(o_pkt_cnt), .o_err_cnt(o_err_cnt)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // Random sink back-pressure that is forced low while stalled
  initial begin
    forever begin
      @(negedge i_clk);
      i_ready = stall ? 1'b0 : ($urandom_range(3, 0) != 0);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before all packets came out", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Called on a falling edge; o_ready depends on state only, so it is stable here
  task automatic send_beat(input chdr_pkg::chdr_beat_t b);
    logic accepted;
    i_beat   = b;
    i_valid  = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = o_ready;
      @(negedge i_clk);
    end
  endtask

  task automatic send_packet(input int nbeats, input int max_gap);
    chdr_pkg::chdr_beat_t b;
    logic [15:0]          len_bytes;
    logic                 bad;
    bad = ($urandom_range(3, 0) == 0);
    if (bad) begin
      len_bytes = 16'((nbeats + $urandom_range(3, 1)) * 8);
    end else begin
      len_bytes = 16'(nbeats * 8 - $urandom_range(7, 0));
    end
    for (int i = 0; i < nbeats; i++) begin
      b.data        = {$urandom, $urandom};
      b.data[47:32] = beat_num;
      if (i == 0) begin
        b.data[31:16] = seq_num;
        b.data[15:0]  = len_bytes;
      end
      b.last = (i == nbeats - 1);
      send_beat(b);
      beat_num++;
      if ((max_gap > 0) && ($urandom_range(3, 0) == 0)) begin
        i_valid = 1'b0;
        repeat ($urandom_range(max_gap, 1)) @(negedge i_clk);
      end
    end
    i_valid = 1'b0;
    seq_num++;
    pkts_sent++;
    if (bad) begin
      pkts_bad++;
    end
  endtask

  task automatic hold_backpressure();
    logic full_seen;
    full_seen = 1'b0;
    for (int c = 0; (c < 200) && !full_seen; c++) begin
      @(negedge i_clk);
      full_seen = !o_ready;
    end
    if (!full_seen) begin
      $display("o_ready never fell while the output was held off");
      errors++;
    end
    repeat (HOLD_CYCLES) @(negedge i_clk);
    @(posedge i_clk);
    stall = 1'b0;
  endtask

  initial begin
    int total;
    void'($urandom(32'h801b_1670));
    i_rst    = 1'b1;
    i_beat   = '0;
    i_valid  = 1'b0;
    i_ready  = 1'b0;
    stall    = 1'b0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    @(negedge i_clk);
    check_value("o_valid", 32'(o_valid), 32'd0);
    check_value("o_len_err", 32'(o_len_err), 32'd0);
    check_value("o_pkt_cnt", 32'(o_pkt_cnt), 32'd0);
    check_value("o_err_cnt", 32'(o_err_cnt), 32'd0);

    repeat (N_RAND) send_packet(int'($urandom_range(MAX_BEATS, 1)), 3);

    // Fill every stage with the output held off
    @(posedge i_clk);
    stall = 1'b1;
    @(negedge i_clk);
    fork
      repeat (N_BURST) send_packet(MAX_BEATS, 0);
      hold_backpressure();
    join

    repeat (N_RAND) send_packet(int'($urandom_range(MAX_BEATS, 1)), 3);

    // Drain until every accepted beat has left the output
    while (dut.props.rd_idx != dut.props.wr_idx) begin
      @(negedge i_clk);
    end
    repeat (4) @(negedge i_clk);
    check_value("o_pkt_cnt", 32'(o_pkt_cnt), 32'(pkts_sent));
    check_value("o_err_cnt", 32'(o_err_cnt), 32'(pkts_bad));

    total = errors + int'(dut.props.fail_cnt);
    $display("Error count: %0d testbench, %0d assertion", errors, dut.props.fail_cnt);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sources.f */
hw/chdr_pkg.sv
hw/axis_flop2.sv
hw/axis_ram_fifo.sv
hw/chdr_ingress_fifo.sv
hw/chdr_hdr_check.sv
hw/chdr_ingress_top.sv
sim/chdr_ingress_assertions.sv
sim/chdr_ingress_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the CHDR ingress testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module chdr_ingress_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vchdr_ingress_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation passed"
exit 0
